/* hdl/polar_bp_pkg.sv */
`default_nettype none

package polar_bp_pkg;

	// ====================
	// code geometry
	localparam int CODE_N = 16;
	localparam int CODE_K = 8;
	localparam int LAYERS = 4;          // LAYERS+1 message columns
	localparam int LAYER_W = 2;

	// ====================
	// message format
	localparam int LLR_W = 8;           // two's complement
	localparam int LLR_MAX = 127;       // saturation and frozen prior

	// set bit = frozen position, information on 7 and 9..15
	localparam logic [CODE_N-1:0] FROZEN_MASK = 16'h017f;

	// ====================
	// schedule
	localparam int ITERATIONS = 40;
	localparam int STEP_CYCLES = 4;
	localparam int STEP_W = $clog2(STEP_CYCLES);
	localparam int ITER_W = $clog2(ITERATIONS);

endpackage

`default_nettype wire

/* hdl/bp_pe.sv */
`default_nettype none

module bp_pe import polar_bp_pkg::*; (
	input wire clk,
	input wire [LLR_W-1:0] r_in1,
	input wire [LLR_W-1:0] r_in2,
	input wire [LLR_W-1:0] l_in1,
	input wire [LLR_W-1:0] l_in2,
	output logic [LLR_W-1:0] r_out1,
	output logic [LLR_W-1:0] r_out2,
	output logic [LLR_W-1:0] l_out1,
	output logic [LLR_W-1:0] l_out2
);

	function automatic logic [LLR_W-1:0] sat_add(input logic signed [LLR_W-1:0] a,
		input logic signed [LLR_W-1:0] b);
		logic signed [LLR_W:0] s;
		s = a + b;
		if (s > (LLR_W+1)'(LLR_MAX))
			return LLR_W'(LLR_MAX);
		else if (s < -((LLR_W+1)'(LLR_MAX)))
			return LLR_W'(-LLR_MAX);
		return s[LLR_W-1:0];
	endfunction

	// min-sum box-plus: sign product, smaller magnitude
	function automatic logic [LLR_W-1:0] g(input logic [LLR_W-1:0] a, input logic [LLR_W-1:0] b);
		logic [LLR_W-1:0] ma;
		logic [LLR_W-1:0] mb;
		logic [LLR_W-1:0] m;
		ma = a[LLR_W-1] ? -a : a;
		mb = b[LLR_W-1] ? -b : b;
		m = (ma < mb) ? ma : mb;
		if (m > LLR_W'(LLR_MAX))
			m = LLR_W'(LLR_MAX); // both inputs at the negative end
		return (a[LLR_W-1] ^ b[LLR_W-1]) ? -m : m;
	endfunction

	logic [LLR_W-1:0] lr_sum;
	logic [LLR_W-1:0] g_rl;

	assign lr_sum = sat_add(l_in2, r_in2);
	assign g_rl = g(r_in1, l_in1); // shared by both second outputs

	always_ff @(posedge clk) begin
		l_out1 <= g(l_in1, lr_sum);
		l_out2 <= sat_add(g_rl, l_in2);
		r_out1 <= g(r_in1, lr_sum);
		r_out2 <= sat_add(g_rl, r_in2);
	end

endmodule

`default_nettype wire

/* hdl/bp_layer.sv */
`default_nettype none

module bp_layer import polar_bp_pkg::*; (
	input wire clk,
	input wire [LAYER_W-1:0] layer,
	input wire [CODE_N*LLR_W-1:0] r_col,
	input wire [CODE_N*LLR_W-1:0] l_col,
	output logic [CODE_N*LLR_W-1:0] r_next,
	output logic [CODE_N*LLR_W-1:0] l_next
);

	logic [LLR_W-1:0] r_a [CODE_N/2];
	logic [LLR_W-1:0] r_b [CODE_N/2];
	logic [LLR_W-1:0] l_a [CODE_N/2];
	logic [LLR_W-1:0] l_b [CODE_N/2];
	logic [LLR_W-1:0] ro_a [CODE_N/2];
	logic [LLR_W-1:0] ro_b [CODE_N/2];
	logic [LLR_W-1:0] lo_a [CODE_N/2];
	logic [LLR_W-1:0] lo_b [CODE_N/2];

	// k-th position with bit s clear: insert a zero at bit s of k
	function automatic int pair_lo(input int k, input int s);
		return ((k >> s) << (s + 1)) | (k & ((1 << s) - 1));
	endfunction

	always_comb begin : gather
		int lo;
		int span;
		span = 1 << layer;
		for (int k = 0; k < CODE_N/2; k++) begin
			lo = pair_lo(k, int'(layer));
			r_a[k] = r_col[lo*LLR_W +: LLR_W];
			r_b[k] = r_col[(lo+span)*LLR_W +: LLR_W];
			l_a[k] = l_col[lo*LLR_W +: LLR_W];
			l_b[k] = l_col[(lo+span)*LLR_W +: LLR_W];
		end
	end

	for (genvar k = 0; k < CODE_N/2; k++) begin : g_pe
		bp_pe pe_i (
			.clk(clk),
			.r_in1(r_a[k]),
			.r_in2(r_b[k]),
			.l_in1(l_a[k]),
			.l_in2(l_b[k]),
			.r_out1(ro_a[k]),
			.r_out2(ro_b[k]),
			.l_out1(lo_a[k]),
			.l_out2(lo_b[k])
		);
	end

	// layer holds for the whole step, so the PE results line up with it
	always_comb begin : scatter
		int lo;
		int span;
		span = 1 << layer;
		r_next = '0;
		l_next = '0;
		for (int k = 0; k < CODE_N/2; k++) begin
			lo = pair_lo(k, int'(layer));
			r_next[lo*LLR_W +: LLR_W] = ro_a[k];
			r_next[(lo+span)*LLR_W +: LLR_W] = ro_b[k];
			l_next[lo*LLR_W +: LLR_W] = lo_a[k];
			l_next[(lo+span)*LLR_W +: LLR_W] = lo_b[k];
		end
	end

endmodule

`default_nettype wire

/* hdl/bp_message_mem.sv */
`default_nettype none

module bp_message_mem import polar_bp_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire write,
	input wire finish,
	input wire [LAYER_W-1:0] layer,
	input wire [CODE_N*LLR_W-1:0] llr,
	input wire [CODE_N*LLR_W-1:0] r_next,
	input wire [CODE_N*LLR_W-1:0] l_next,
	output logic [CODE_N*LLR_W-1:0] r_col,
	output logic [CODE_N*LLR_W-1:0] l_col,
	output logic [CODE_K-1:0] decoded
);

	logic [CODE_N*LLR_W-1:0] r_mem [LAYERS+1];
	logic [CODE_N*LLR_W-1:0] l_mem [LAYERS+1];
	logic [CODE_N*LLR_W-1:0] r_prior;
	logic [LAYER_W:0] layer_up;
	logic [CODE_K-1:0] hard;

	// position of the k-th information bit
	function automatic int info_pos(input int k);
		int n;
		n = 0;
		for (int i = 0; i < CODE_N; i++) begin
			if (!FROZEN_MASK[i]) begin
				if (n == k)
					return i;
				n++;
			end
		end
		return 0;
	endfunction

	assign layer_up = {1'b0, layer} + 1'b1;

	assign r_col = r_mem[layer];      // R flows rightward out of column layer
	assign l_col = l_mem[layer_up];   // L flows leftward out of column layer+1

	// frozen bits are known zeros, so they start fully confident
	for (genvar i = 0; i < CODE_N; i++) begin : g_prior
		assign r_prior[i*LLR_W +: LLR_W] = FROZEN_MASK[i] ? LLR_W'(LLR_MAX) : '0;
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int c = 0; c <= LAYERS; c++) begin
				r_mem[c] <= (c == 0) ? r_prior : '0;
				l_mem[c] <= (c == LAYERS) ? llr : '0;
			end
		end else if (write) begin
			r_mem[layer_up] <= r_next;
			l_mem[layer] <= l_next;
		end
	end

	// ====================
	// hard decision
	for (genvar k = 0; k < CODE_K; k++) begin : g_hard
		assign hard[k] = l_mem[0][info_pos(k)*LLR_W + LLR_W - 1]; // sign bit
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			decoded <= '0;
		else if (finish)
			decoded <= hard;
	end

endmodule

`default_nettype wire

/* hdl/bp_schedule_ctrl.sv */
`default_nettype none

module bp_schedule_ctrl import polar_bp_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start,
	output logic busy,
	output logic load,
	output logic write,
	output logic [LAYER_W-1:0] layer,
	output logic sweep_left,
	output logic finish
);

	// idle: !busy, left sweep: busy & sweep_left, right sweep: busy & !sweep_left
	logic [STEP_W-1:0] step_cnt;
	logic [ITER_W-1:0] iter_cnt;
	logic last_layer;

	assign load = start && !busy;
	assign write = busy && (step_cnt == STEP_W'(STEP_CYCLES - 1));
	assign last_layer = (layer == LAYER_W'(LAYERS - 1));
	assign finish = write && !sweep_left && last_layer
		&& (iter_cnt == ITER_W'(ITERATIONS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			sweep_left <= 1'b0;
			layer <= '0;
			step_cnt <= '0;
			iter_cnt <= '0;
		end else if (load) begin
			busy <= 1'b1;
			sweep_left <= 1'b1;
			layer <= LAYER_W'(LAYERS - 1); // leftward sweep starts at the channel side
			step_cnt <= '0;
			iter_cnt <= '0;
		end else if (busy) begin
			step_cnt <= write ? '0 : step_cnt + 1'b1;
			if (write) begin
				if (sweep_left) begin
					if (layer == '0)
						sweep_left <= 1'b0; // layer 0 runs again heading right
					else
						layer <= layer - 1'b1;
				end else if (last_layer) begin
					if (finish) begin
						busy <= 1'b0;
					end else begin
						sweep_left <= 1'b1;
						iter_cnt <= iter_cnt + 1'b1;
					end
				end else begin
					layer <= layer + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/polar_bp_decoder.sv */
`default_nettype none

module polar_bp_decoder import polar_bp_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire [CODE_N*LLR_W-1:0] llr,
	output logic busy,
	output logic [CODE_K-1:0] decoded
);

	logic load;
	logic write;
	logic finish;
	logic [LAYER_W-1:0] layer;
	logic [CODE_N*LLR_W-1:0] r_col;
	logic [CODE_N*LLR_W-1:0] l_col;
	logic [CODE_N*LLR_W-1:0] r_next;
	logic [CODE_N*LLR_W-1:0] l_next;

	bp_schedule_ctrl ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.load(load),
		.write(write),
		.layer(layer),
		.sweep_left(),      // both directions update every step
		.finish(finish)
	);

	bp_message_mem mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.write(write),
		.finish(finish),
		.layer(layer),
		.llr(llr),
		.r_next(r_next),
		.l_next(l_next),
		.r_col(r_col),
		.l_col(l_col),
		.decoded(decoded)
	);

	bp_layer layer_i (
		.clk(clk),
		.layer(layer),
		.r_col(r_col),
		.l_col(l_col),
		.r_next(r_next),
		.l_next(l_next)
	);

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

endmodule

`default_nettype wire

/* verif/tb_polar_bp_decoder.sv */
`default_nettype none

module tb_polar_bp_decoder import polar_bp_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DECODE_CYCLES = ITERATIONS * 2 * LAYERS * STEP_CYCLES;
	localparam int PLANNED_DECODES = 33;
	localparam int WATCHDOG_NS = (PLANNED_DECODES + 4) * DECODE_CYCLES * 8;

	logic clk;
	logic rst_n;
	logic start;
	logic [CODE_N*LLR_W-1:0] llr;
	logic busy;
	logic [CODE_K-1:0] decoded;
	logic [31:0] lfsr_state = 32'hd007_b59c;
	string cur_test;
	int test_errs;
	int pass_cnt;
	int fail_cnt;

	tb_clk_gen clk_gen_i (.clk(clk));

	polar_bp_decoder polar_bp_decoder_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.llr(llr),
		.busy(busy),
		.decoded(decoded)
	);

	// ====================
	// stimulus models
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// polar encoder mapping bit 0 to +m and bit 1 to -m
	function automatic logic [CODE_N*LLR_W-1:0] encode(input logic [CODE_K-1:0] info,
		input int m);
		logic [CODE_N-1:0] x;
		logic [CODE_N*LLR_W-1:0] v;
		int k;
		x = '0;
		k = 0;
		for (int i = 0; i < CODE_N; i++) begin
			if (!FROZEN_MASK[i]) begin
				x[i] = info[k];
				k++;
			end
		end
		for (int s = 0; s < LAYERS; s++) begin
			for (int a = 0; a < CODE_N; a++) begin
				if (((a >> s) & 1) == 0)
					x[a] = x[a] ^ x[a + (1 << s)];
			end
		end
		for (int i = 0; i < CODE_N; i++)
			v[i*LLR_W +: LLR_W] = x[i] ? LLR_W'(-m) : LLR_W'(m);
		return v;
	endfunction

	// ====================
	// checks and drivers
	task automatic compare_decoded(input string name, input logic [CODE_K-1:0] exp,
		input logic [CODE_K-1:0] act);
		if (act !== exp) begin
			$display("** Error %s: decoded expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic compare_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: busy expected %b, actual %b", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("%s: ok", cur_test);
			pass_cnt++;
		end else begin
			$display("%s: %0d check(s) wrong", cur_test, test_errs);
			fail_cnt++;
		end
		test_errs = 0;
	endtask

	task automatic start_decode(input logic [CODE_N*LLR_W-1:0] word);
		@(posedge clk);
		#1;
		llr = word;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 2 * DECODE_CYCLES) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (busy) begin
			$display("%s: busy still high after %0d cycles", cur_test, n);
			test_errs++;
		end
	endtask

	task automatic check_decode(input logic [CODE_K-1:0] info, input int m);
		start_decode(encode(info, m));
		compare_busy(cur_test, 1'b1, busy);
		wait_idle();
		compare_busy(cur_test, 1'b0, busy);
		compare_decoded(cur_test, info, decoded);
	endtask

	// ====================
	// directed tests
	task automatic reset_and_zero_word();
		cur_test = "reset_and_zero_word";
		compare_busy(cur_test, 1'b0, busy);
		compare_decoded(cur_test, '0, decoded);
		check_decode('0, 127);
		end_test();
	endtask

	task automatic single_bit_words();
		cur_test = "single_bit_words";
		for (int k = 0; k < CODE_K; k++)
			check_decode(CODE_K'(1) << k, 100);
		end_test();
	endtask

	task automatic random_words();
		logic [CODE_K-1:0] info;
		int m;
		cur_test = "random_words";
		for (int i = 0; i < 20; i++) begin
			info = CODE_K'(rand_bits(CODE_K));
			m = 20 + int'(rand_bits(7)) % 108;
			check_decode(info, m);
		end
		end_test();
	endtask

	task automatic start_while_busy();
		logic [CODE_K-1:0] first;
		logic [CODE_K-1:0] second;
		cur_test = "start_while_busy";
		first = CODE_K'(rand_bits(CODE_K));
		second = CODE_K'(rand_bits(CODE_K)) | CODE_K'(1); // lsb set keeps it nonzero
		second[CODE_K-1] = ~first[CODE_K-1]; // top bit never matches first
		start_decode(encode(first, 90));
		repeat (10) @(posedge clk);
		start_decode(encode(second, 90)); // must be ignored
		wait_idle();
		compare_decoded(cur_test, first, decoded);
		check_decode(second, 90);
		end_test();
	endtask

	task automatic reset_mid_decode();
		cur_test = "reset_mid_decode";
		start_decode(encode(CODE_K'(rand_bits(CODE_K)), 70));
		repeat (100) @(posedge clk);
		#1;
		rst_n = 1'b0;
		#1;
		compare_busy(cur_test, 1'b0, busy);
		compare_decoded(cur_test, '0, decoded);
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_decode(8'ha5, 60);
		end_test();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the decodes did not complete within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		llr = '0;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_zero_word();
		single_bit_words();
		random_words();
		start_while_busy();
		reset_mid_decode();
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/polar_bp_pkg.sv
hdl/bp_pe.sv
hdl/bp_layer.sv
hdl/bp_message_mem.sv
hdl/bp_schedule_ctrl.sv
hdl/polar_bp_decoder.sv
verif/tb_clk_gen.sv
verif/tb_polar_bp_decoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_polar_bp_decoder
LOG ?= sim.log
OBJ_DIR ?= obj_dir
FLAGS ?= --binary --timing --timescale 1ns/100ps -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
